//--- rtl/tiny86_pkg.sv
package tiny86_pkg;

  // Datapath and memory sizing.
  localparam int XLEN      = 32;
  localparam int RAM_DEPTH = 256;
  localparam int RAM_AW    = 8;
  localparam int PADDR_W   = 12;

  typedef logic [2:0] reg_idx_t;

  // Reduced opcode set. Unknown codes only advance EIP.
  typedef enum logic [5:0] {
    ADD  = 6'd0,
    SUB  = 6'd1,
    AND  = 6'd2,
    XOR  = 6'd3,
    MOVI = 6'd4,
    LD   = 6'd5,
    ST   = 6'd6,
    JNZ  = 6'd7
  } opcode_e;

  // Instruction word layout. Bits 19..16 are reserved.
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    dst;
    reg_idx_t    src;
    logic [3:0]  rsvd;
    logic [15:0] imm;
  } instr_t;

  // EFLAGS bit positions. Only CF and ZF are kept.
  localparam int FLAG_CF = 0;
  localparam int FLAG_ZF = 6;

  // APB register map.
  localparam logic [PADDR_W-1:0] ADDR_INSTR    = 12'h000;
  localparam logic [PADDR_W-1:0] ADDR_STATUS   = 12'h004;
  localparam logic [PADDR_W-1:0] ADDR_GPR_BASE = 12'h040;
  localparam logic [PADDR_W-1:0] ADDR_EIP      = 12'h060;
  localparam logic [PADDR_W-1:0] ADDR_EFLAGS   = 12'h064;
  localparam logic [PADDR_W-1:0] ADDR_RAM_BASE = 12'h400;

endpackage

//--- rtl/mem_if.sv
`timescale 1ns/1ps

// One word-wide request/grant channel into the shared RAM.
interface mem_if;
  import tiny86_pkg::*;

  logic              req;
  logic              we;
  logic [RAM_AW-1:0] addr;
  logic [XLEN-1:0]   wdata;
  logic [XLEN-1:0]   rdata;
  logic              gnt;

  modport requester (output req, output we, output addr, output wdata,
                     input rdata, input gnt);
  modport arbiter (input req, input we, input addr, input wdata,
                   output rdata, output gnt);

endinterface

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic                          i_clk,
  input  logic                          i_en,
  input  logic                          i_we,
  input  logic [tiny86_pkg::RAM_AW-1:0] i_addr,
  input  logic [tiny86_pkg::XLEN-1:0]   i_wdata,
  output logic [tiny86_pkg::XLEN-1:0]   o_rdata
);
  import tiny86_pkg::*;

  logic [XLEN-1:0] mem [RAM_DEPTH];

  // Contents start out zero.
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) mem[i] = '0;
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_we) mem[i_addr] <= i_wdata;
      o_rdata <= mem[i_addr];
    end
  end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  mem_if.arbiter                        core,
  mem_if.arbiter                        host,
  output logic                          o_ram_en,
  output logic                          o_ram_we,
  output logic [tiny86_pkg::RAM_AW-1:0] o_ram_addr,
  output logic [tiny86_pkg::XLEN-1:0]   o_ram_wdata,
  input  logic [tiny86_pkg::XLEN-1:0]   i_ram_rdata
);
  import tiny86_pkg::*;

  logic rd_core_q;

  // Core always wins, host only gets an idle cycle.
  assign core.gnt = core.req;
  assign host.gnt = host.req && !core.req;

  assign o_ram_en    = core.req || host.req;
  assign o_ram_we    = core.req ? core.we : host.we;
  assign o_ram_addr  = core.req ? core.addr : host.addr;
  assign o_ram_wdata = core.req ? core.wdata : host.wdata;

  // Remember the owner so read data returns to it a cycle later.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_core_q <= 1'b0;
    end else if (o_ram_en) begin
      rd_core_q <= core.req;
    end
  end

  assign core.rdata = rd_core_q ? i_ram_rdata : '0;
  assign host.rdata = rd_core_q ? '0 : i_ram_rdata;

  // The host is held off during a step, so the two requests never meet.
  a_req_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $onehot0({core.req, host.req}));

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic                        i_wr_en,
  input  logic                        i_wr_gpr_en,
  input  tiny86_pkg::reg_idx_t        i_wr_idx,
  input  logic [tiny86_pkg::XLEN-1:0] i_wr_data,
  input  logic [tiny86_pkg::XLEN-1:0] i_wr_eip,
  input  logic [tiny86_pkg::XLEN-1:0] i_wr_eflags,
  input  logic                        i_host_we,
  input  tiny86_pkg::reg_idx_t        i_host_idx,
  input  logic                        i_host_sel_eip,
  input  logic [tiny86_pkg::XLEN-1:0] i_host_wdata,
  input  tiny86_pkg::reg_idx_t        i_rd_dst_idx,
  input  tiny86_pkg::reg_idx_t        i_rd_src_idx,
  output logic [tiny86_pkg::XLEN-1:0] o_rd_dst,
  output logic [tiny86_pkg::XLEN-1:0] o_rd_src,
  output logic [tiny86_pkg::XLEN-1:0] o_gpr [8],
  output logic [tiny86_pkg::XLEN-1:0] o_eip,
  output logic [tiny86_pkg::XLEN-1:0] o_eflags
);
  import tiny86_pkg::*;

  logic [XLEN-1:0] gpr_q [8];
  logic [XLEN-1:0] eip_q;
  logic [XLEN-1:0] eflags_q;

  // Core writeback updates a GPR, EIP and EFLAGS together.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 8; i++) gpr_q[i] <= '0;
      eip_q    <= '0;
      eflags_q <= '0;
    end else if (i_wr_en) begin
      if (i_wr_gpr_en) gpr_q[i_wr_idx] <= i_wr_data;
      eip_q    <= i_wr_eip;
      eflags_q <= i_wr_eflags;
    end else if (i_host_we) begin
      if (i_host_sel_eip) eip_q <= i_host_wdata;
      else gpr_q[i_host_idx] <= i_host_wdata;
    end
  end

  assign o_rd_dst = gpr_q[i_rd_dst_idx];
  assign o_rd_src = gpr_q[i_rd_src_idx];
  assign o_gpr    = gpr_q;
  assign o_eip    = eip_q;
  assign o_eflags = eflags_q;

  // Host writes are held off while a step runs.
  a_no_dual_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_wr_en && i_host_we));

endmodule

//--- rtl/step_exec.sv
`timescale 1ns/1ps

module step_exec (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic                        i_start,
  input  logic [tiny86_pkg::XLEN-1:0] i_instr,
  input  logic [tiny86_pkg::XLEN-1:0] i_rd_dst,
  input  logic [tiny86_pkg::XLEN-1:0] i_rd_src,
  input  logic [tiny86_pkg::XLEN-1:0] i_eip,
  input  logic [tiny86_pkg::XLEN-1:0] i_eflags,
  output logic                        o_busy,
  output tiny86_pkg::reg_idx_t        o_rd_dst_idx,
  output tiny86_pkg::reg_idx_t        o_rd_src_idx,
  output logic                        o_wr_en,
  output logic                        o_wr_gpr_en,
  output tiny86_pkg::reg_idx_t        o_wr_idx,
  output logic [tiny86_pkg::XLEN-1:0] o_wr_data,
  output logic [tiny86_pkg::XLEN-1:0] o_wr_eip,
  output logic [tiny86_pkg::XLEN-1:0] o_wr_eflags,
  mem_if.requester                    mem
);
  import tiny86_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_WB} state_e;

  state_e            state_q;
  instr_t            instr_q;
  logic              req_q;
  logic              ld_wait_q;
  logic              gpr_we_q;
  logic [XLEN-1:0]   res_q;
  logic [XLEN-1:0]   eip_q;
  logic [XLEN-1:0]   flags_q;
  logic [XLEN-1:0]   imm_sext;
  logic [XLEN-1:0]   eip_seq;
  logic [XLEN:0]     alu;
  logic [XLEN-1:0]   exec_res;
  logic              exec_gpr_we;
  logic [XLEN-1:0]   flags_nxt;
  logic [XLEN-1:0]   eip_nxt;
  logic              is_mem;

  assign o_rd_dst_idx = instr_q.dst;
  assign o_rd_src_idx = instr_q.src;

  assign imm_sext = {{(XLEN-16){instr_q.imm[15]}}, instr_q.imm};
  assign eip_seq  = i_eip + 32'd4;
  assign is_mem   = (instr_q.opcode == LD) || (instr_q.opcode == ST);

  // ALU, flag logic and branch target.
  always_comb begin
    alu         = '0;
    exec_res    = '0;
    exec_gpr_we = 1'b0;
    flags_nxt   = i_eflags;
    eip_nxt     = eip_seq;
    case (instr_q.opcode)
      ADD: alu = {1'b0, i_rd_dst} + {1'b0, i_rd_src};
      SUB: alu = {1'b0, i_rd_dst} - {1'b0, i_rd_src};
      AND: alu = {1'b0, i_rd_dst & i_rd_src};
      XOR: alu = {1'b0, i_rd_dst ^ i_rd_src};
      default: alu = '0;
    endcase
    case (instr_q.opcode)
      ADD, SUB, AND, XOR: begin
        exec_res           = alu[XLEN-1:0];
        exec_gpr_we        = 1'b1;
        flags_nxt[FLAG_CF] = alu[XLEN];
        flags_nxt[FLAG_ZF] = alu[XLEN-1:0] == '0;
      end
      MOVI: begin
        exec_res    = {{(XLEN-16){1'b0}}, instr_q.imm};
        exec_gpr_we = 1'b1;
      end
      LD: exec_gpr_we = 1'b1;
      JNZ: begin
        if (!i_eflags[FLAG_ZF]) begin
          eip_nxt = eip_seq + {imm_sext[XLEN-3:0], 2'b00};
        end
      end
      default: exec_gpr_we = 1'b0;
    endcase
  end

  // Address and store data stay stable for the whole step.
  assign mem.req   = req_q;
  assign mem.we    = instr_q.opcode == ST;
  assign mem.addr  = i_rd_src[RAM_AW-1:0] + imm_sext[RAM_AW-1:0];
  assign mem.wdata = i_rd_dst;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= S_IDLE;
      req_q     <= 1'b0;
      ld_wait_q <= 1'b0;
      gpr_we_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (i_start) state_q <= S_EXEC;
        S_EXEC: begin
          gpr_we_q <= exec_gpr_we;
          req_q    <= is_mem;
          state_q  <= is_mem ? S_MEM : S_WB;
        end
        S_MEM: begin
          if (ld_wait_q) begin
            ld_wait_q <= 1'b0;
            state_q   <= S_WB;
          end else if (mem.gnt) begin
            req_q <= 1'b0;
            if (mem.we) state_q <= S_WB;
            else ld_wait_q <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == S_IDLE && i_start) begin
      instr_q <= instr_t'(i_instr);
    end
    if (state_q == S_EXEC) begin
      res_q   <= exec_res;
      eip_q   <= eip_nxt;
      flags_q <= flags_nxt;
    end else if (ld_wait_q) begin
      res_q <= mem.rdata;
    end
  end

  assign o_busy      = state_q != S_IDLE;
  assign o_wr_en     = state_q == S_WB;
  assign o_wr_gpr_en = gpr_we_q;
  assign o_wr_idx    = instr_q.dst;
  assign o_wr_data   = res_q;
  assign o_wr_eip    = eip_q;
  assign o_wr_eflags = flags_q;

  // The request and its fields hold until the arbiter grants it.
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    mem.req && !mem.gnt |=> mem.req && $stable(mem.addr) && $stable(mem.we) &&
    $stable(mem.wdata));

endmodule

//--- rtl/step_apb_regs.sv
`timescale 1ns/1ps

module step_apb_regs (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_psel,
  input  logic                            i_penable,
  input  logic                            i_pwrite,
  input  logic [tiny86_pkg::PADDR_W-1:0]  i_paddr,
  input  logic [tiny86_pkg::XLEN-1:0]     i_pwdata,
  input  logic                            i_busy,
  input  logic [tiny86_pkg::XLEN-1:0]     i_gpr [8],
  input  logic [tiny86_pkg::XLEN-1:0]     i_eip,
  input  logic [tiny86_pkg::XLEN-1:0]     i_eflags,
  output logic [tiny86_pkg::XLEN-1:0]     o_prdata,
  output logic                            o_pready,
  output logic                            o_pslverr,
  output logic                            o_start,
  output logic [tiny86_pkg::XLEN-1:0]     o_instr,
  output logic                            o_host_we,
  output tiny86_pkg::reg_idx_t            o_host_idx,
  output logic                            o_host_sel_eip,
  output logic [tiny86_pkg::XLEN-1:0]     o_host_wdata,
  mem_if.requester                        ram
);
  import tiny86_pkg::*;

  logic     access;
  logic     is_instr;
  logic     is_status;
  logic     is_gpr;
  logic     is_eip;
  logic     is_eflags;
  logic     is_ram;
  logic     err;
  logic     ram_done;
  logic     rd_pend_q;
  reg_idx_t gpr_idx;

  // Any access waits in its access phase while a step runs.
  assign access = i_psel && i_penable && !i_busy;

  assign is_instr  = i_paddr == ADDR_INSTR;
  assign is_status = i_paddr == ADDR_STATUS;
  assign is_gpr    = (i_paddr[PADDR_W-1:5] == ADDR_GPR_BASE[PADDR_W-1:5]) && (i_paddr[1:0] == 2'b00);
  assign is_eip    = i_paddr == ADDR_EIP;
  assign is_eflags = i_paddr == ADDR_EFLAGS;
  assign is_ram    = (i_paddr[PADDR_W-1:10] == ADDR_RAM_BASE[PADDR_W-1:10]) &&
                     (i_paddr[1:0] == 2'b00);
  assign gpr_idx   = i_paddr[4:2];

  assign err = !(is_instr || is_status || is_gpr || is_eip || is_eflags || is_ram) ||
               (i_pwrite && is_eflags) || (!i_pwrite && is_instr);

  // RAM window. Writes finish in the grant cycle, reads one cycle later.
  assign ram.req   = access && is_ram && !err && !rd_pend_q;
  assign ram.we    = i_pwrite;
  assign ram.addr  = i_paddr[RAM_AW+1:2];
  assign ram.wdata = i_pwdata;
  assign ram_done  = rd_pend_q || (ram.gnt && i_pwrite);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= ram.gnt && !ram.we;
    end
  end

  assign o_pready  = access && (err || !is_ram || ram_done);
  assign o_pslverr = o_pready && err;

  always_comb begin
    o_prdata = '0;
    if (is_status) begin
      o_prdata[0] = i_busy;
    end else if (is_gpr) begin
      o_prdata = i_gpr[gpr_idx];
    end else if (is_eip) begin
      o_prdata = i_eip;
    end else if (is_eflags) begin
      o_prdata = i_eflags;
    end else if (is_ram) begin
      o_prdata = ram.rdata;
    end
  end

  // Writing INSTR launches one step.
  assign o_start = access && i_pwrite && is_instr;
  assign o_instr = i_pwdata;

  assign o_host_we      = access && i_pwrite && (is_gpr || is_eip);
  assign o_host_idx     = gpr_idx;
  assign o_host_sel_eip = is_eip;
  assign o_host_wdata   = i_pwdata;

  // A start is only accepted when idle, and the engine goes busy right after.
  a_start_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_start |-> !i_busy ##1 i_busy);

endmodule

//--- rtl/tiny86_top.sv
`timescale 1ns/1ps

module tiny86_top (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [tiny86_pkg::PADDR_W-1:0] i_paddr,
  input  logic [tiny86_pkg::XLEN-1:0]    i_pwdata,
  output logic [tiny86_pkg::XLEN-1:0]    o_prdata,
  output logic                           o_pready,
  output logic                           o_pslverr
);
  import tiny86_pkg::*;

  logic              busy;
  logic              start;
  logic [XLEN-1:0]   instr;
  logic              host_we;
  reg_idx_t          host_idx;
  logic              host_sel_eip;
  logic [XLEN-1:0]   host_wdata;
  reg_idx_t          rd_dst_idx;
  reg_idx_t          rd_src_idx;
  logic [XLEN-1:0]   rd_dst;
  logic [XLEN-1:0]   rd_src;
  logic              wr_en;
  logic              wr_gpr_en;
  reg_idx_t          wr_idx;
  logic [XLEN-1:0]   wr_data;
  logic [XLEN-1:0]   wr_eip;
  logic [XLEN-1:0]   wr_eflags;
  logic [XLEN-1:0]   gpr [8];
  logic [XLEN-1:0]   eip;
  logic [XLEN-1:0]   eflags;
  logic              ram_en;
  logic              ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [XLEN-1:0]   ram_wdata;
  logic [XLEN-1:0]   ram_rdata;

  mem_if core_mem ();
  mem_if host_mem ();

  step_apb_regs apb_i (
    .i_clk, .i_arst_n, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
    .i_busy(busy), .i_gpr(gpr), .i_eip(eip), .i_eflags(eflags),
    .o_prdata, .o_pready, .o_pslverr,
    .o_start(start), .o_instr(instr),
    .o_host_we(host_we), .o_host_idx(host_idx),
    .o_host_sel_eip(host_sel_eip), .o_host_wdata(host_wdata),
    .ram(host_mem.requester)
  );

  step_exec exec_i (
    .i_clk, .i_arst_n, .i_start(start), .i_instr(instr),
    .i_rd_dst(rd_dst), .i_rd_src(rd_src), .i_eip(eip), .i_eflags(eflags),
    .o_busy(busy), .o_rd_dst_idx(rd_dst_idx), .o_rd_src_idx(rd_src_idx),
    .o_wr_en(wr_en), .o_wr_gpr_en(wr_gpr_en), .o_wr_idx(wr_idx),
    .o_wr_data(wr_data), .o_wr_eip(wr_eip), .o_wr_eflags(wr_eflags),
    .mem(core_mem.requester)
  );

  regfile regfile_i (
    .i_clk, .i_arst_n,
    .i_wr_en(wr_en), .i_wr_gpr_en(wr_gpr_en), .i_wr_idx(wr_idx),
    .i_wr_data(wr_data), .i_wr_eip(wr_eip), .i_wr_eflags(wr_eflags),
    .i_host_we(host_we), .i_host_idx(host_idx),
    .i_host_sel_eip(host_sel_eip), .i_host_wdata(host_wdata),
    .i_rd_dst_idx(rd_dst_idx), .i_rd_src_idx(rd_src_idx),
    .o_rd_dst(rd_dst), .o_rd_src(rd_src),
    .o_gpr(gpr), .o_eip(eip), .o_eflags(eflags)
  );

  mem_arbiter arb_i (
    .i_clk, .i_arst_n,
    .core(core_mem.arbiter), .host(host_mem.arbiter),
    .o_ram_en(ram_en), .o_ram_we(ram_we), .o_ram_addr(ram_addr),
    .o_ram_wdata(ram_wdata), .i_ram_rdata(ram_rdata)
  );

  data_ram ram_i (
    .i_clk, .i_en(ram_en), .i_we(ram_we), .i_addr(ram_addr),
    .i_wdata(ram_wdata), .o_rdata(ram_rdata)
  );

endmodule

//--- tb/tiny86_tb.sv
`timescale 1ns/1ps

module tiny86_tb;
  import tiny86_pkg::*;

  logic               clk;
  logic               arst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [PADDR_W-1:0] paddr;
  logic [XLEN-1:0]    pwdata;
  logic [XLEN-1:0]    prdata;
  logic               pready;
  logic               pslverr;

  integer seed = 98646;
  int     failures = 0;

  // Reference model of the architectural state and the data RAM.
  logic [XLEN-1:0] exp_gpr [8];
  logic [XLEN-1:0] exp_eip;
  logic            exp_zf;
  logic            exp_cf;
  logic [XLEN-1:0] exp_ram [RAM_DEPTH];

  // Outcome of the last APB transfer.
  logic [XLEN-1:0] rd_data;
  logic            rd_err;
  int              wait_cycles;

  tiny86_top dut_i (
    .i_clk(clk), .i_arst_n(arst_n), .i_psel(psel), .i_penable(penable),
    .i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata),
    .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with(input string msg);
    failures++;
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      stop_with($sformatf("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp));
    end
  endtask

  task automatic check_flags(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      stop_with($sformatf("mismatch at %0t: EFLAGS got 0x%h expected 0x%h", $time, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic [XLEN-1:0] flags_word(input logic zf, input logic cf);
    logic [XLEN-1:0] w;
    w          = '0;
    w[FLAG_ZF] = zf;
    w[FLAG_CF] = cf;
    return w;
  endfunction

  function automatic logic [PADDR_W-1:0] gpr_addr(input reg_idx_t idx);
    return ADDR_GPR_BASE | {7'b0000000, idx, 2'b00};
  endfunction

  function automatic logic [PADDR_W-1:0] window_addr(input logic [RAM_AW-1:0] a);
    return ADDR_RAM_BASE | {2'b00, a, 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] make_instr(input opcode_e op, input reg_idx_t d,
                                                 input reg_idx_t s, input logic [15:0] imm);
    return {op, d, s, 4'b0000, imm};
  endfunction

  // Setup on one falling edge, access phase from the next, back to back transfers.
  task automatic bus_cycle(input logic wr, input logic [PADDR_W-1:0] addr,
                           input logic [XLEN-1:0] wdata);
    int cycles;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    cycles  = 0;
    #1;
    while (!pready) begin
      if (cycles == 200) stop_with("APB transfer timed out after 200 cycles");
      cycles++;
      @(negedge clk);
      #1;
    end
    rd_data     = prdata;
    rd_err      = pslverr;
    wait_cycles = cycles;
  endtask

  task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    bus_cycle(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [PADDR_W-1:0] addr);
    bus_cycle(1'b0, addr, '0);
  endtask

  task automatic wait_idle();
    int polls;
    polls = 0;
    apb_read(ADDR_STATUS);
    while (rd_data[0]) begin
      if (polls == 200) stop_with("step did not finish within 200 status polls");
      polls++;
      apb_read(ADDR_STATUS);
    end
  endtask

  task automatic set_gpr(input reg_idx_t idx, input logic [XLEN-1:0] val);
    apb_write(gpr_addr(idx), val);
    check_err("pslverr", rd_err, 1'b0);
    exp_gpr[idx] = val;
  endtask

  // Model update from the instruction semantics.
  task automatic apply_model(input logic [XLEN-1:0] w);
    reg_idx_t          d;
    reg_idx_t          s;
    logic [XLEN-1:0]   sx;
    logic [XLEN-1:0]   res;
    logic              cf;
    logic              alu_op;
    logic [RAM_AW-1:0] a;
    d      = w[25:23];
    s      = w[22:20];
    sx     = {{16{w[15]}}, w[15:0]};
    a      = RAM_AW'((exp_gpr[s] + sx) % RAM_DEPTH);
    alu_op = 1'b1;
    res    = '0;
    cf     = 1'b0;
    case (opcode_e'(w[31:26]))
      ADD: begin
        res = exp_gpr[d] + exp_gpr[s];
        cf  = res < exp_gpr[d];
      end
      SUB: begin
        res = exp_gpr[d] - exp_gpr[s];
        cf  = exp_gpr[d] < exp_gpr[s];
      end
      AND: res = exp_gpr[d] & exp_gpr[s];
      XOR: res = exp_gpr[d] ^ exp_gpr[s];
      default: alu_op = 1'b0;
    endcase
    if (alu_op) begin
      exp_gpr[d] = res;
      exp_cf     = cf;
      exp_zf     = res == '0;
    end
    exp_eip = exp_eip + 32'd4;
    case (opcode_e'(w[31:26]))
      MOVI: exp_gpr[d] = {16'h0000, w[15:0]};
      LD:   exp_gpr[d] = exp_ram[a];
      ST:   exp_ram[a] = exp_gpr[d];
      JNZ: begin
        if (!exp_zf) exp_eip = exp_eip + sx * 4;
      end
      default: ;
    endcase
  endtask

  task automatic run_step(input logic [XLEN-1:0] w);
    apb_write(ADDR_INSTR, w);
    check_err("pslverr", rd_err, 1'b0);
    apply_model(w);
  endtask

  task automatic compare_state(input reg_idx_t d);
    apb_read(gpr_addr(d));
    check_word($sformatf("gpr[%0d]", d), rd_data, exp_gpr[d]);
    apb_read(ADDR_EIP);
    check_word("EIP", rd_data, exp_eip);
    apb_read(ADDR_EFLAGS);
    check_flags(rd_data, flags_word(exp_zf, exp_cf));
  endtask

  initial begin
    logic [XLEN-1:0]   r;
    logic [XLEN-1:0]   r2;
    reg_idx_t          d;
    reg_idx_t          s;
    opcode_e           op;
    logic [RAM_AW-1:0] a;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    arst_n  = 1'b0;
    for (int i = 0; i < 8; i++) exp_gpr[i] = '0;
    for (int i = 0; i < RAM_DEPTH; i++) exp_ram[i] = '0;
    exp_eip = '0;
    exp_zf  = 1'b0;
    exp_cf  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Register access after reset.
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      set_gpr(reg_idx_t'(i), r);
    end
    r = $random(seed);
    apb_write(ADDR_EIP, {r[31:2], 2'b00});
    exp_eip = {r[31:2], 2'b00};
    for (int i = 0; i < 8; i++) begin
      apb_read(gpr_addr(reg_idx_t'(i)));
      check_word($sformatf("gpr[%0d]", i), rd_data, exp_gpr[i]);
    end
    apb_read(ADDR_EIP);
    check_word("EIP", rd_data, exp_eip);
    apb_read(ADDR_EFLAGS);
    check_flags(rd_data, flags_word(1'b0, 1'b0));

    // ALU and MOVI steps with operands steered toward carry, borrow and zero.
    for (int n = 0; n < 300; n++) begin
      r  = $random(seed);
      r2 = $random(seed);
      d  = r[2:0];
      s  = r[5:3];
      op = opcode_e'({3'b000, r[10:8] % 3'd5});
      case (r[13:12])
        2'd1: begin
          set_gpr(d, {8'hFF, r2[23:0]});
          set_gpr(s, {4'hF, r2[27:0]});
        end
        2'd2: set_gpr(s, exp_gpr[d]);
        2'd3: begin
          set_gpr(d, {16'h0000, r2[15:0]});
          set_gpr(s, {r2[31:16] | 16'h8000, 16'h0000});
        end
        default: ;
      endcase
      run_step(make_instr(op, d, s, r[31:16]));
      if (n % 4 == 0) begin
        // This read arrives while the step runs and must be held off.
        apb_read(gpr_addr(d));
        if (wait_cycles == 0) stop_with("register read during a step was not held off");
        check_word($sformatf("gpr[%0d]", d), rd_data, exp_gpr[d]);
      end
      wait_idle();
      compare_state(d);
    end

    // Loads and stores mixed with host window traffic on a small address pool.
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      a = {r[2:0], 5'b00101};
      d = r[5:3];
      s = r[8:6];
      case (r[10:9])
        2'd0: begin
          r2 = $random(seed);
          apb_write(window_addr(a), r2);
          check_err("pslverr", rd_err, 1'b0);
          exp_ram[a] = r2;
        end
        2'd1: begin
          apb_read(window_addr(a));
          check_err("pslverr", rd_err, 1'b0);
          check_word($sformatf("ram[%0d]", a), rd_data, exp_ram[a]);
        end
        default: begin
          op = r[9] ? LD : ST;
          run_step(make_instr(op, d, s, {r[31:24], a - exp_gpr[s][RAM_AW-1:0]}));
          wait_idle();
          compare_state(d);
        end
      endcase
    end

    // Branches with ZF set by an equal or unequal SUB.
    for (int n = 0; n < 40; n++) begin
      r = $random(seed);
      set_gpr(3'd0, r);
      set_gpr(3'd1, r[0] ? r : r + 32'd1);
      run_step(make_instr(SUB, 3'd0, 3'd1, 16'h0000));
      wait_idle();
      r2 = $random(seed);
      run_step(make_instr(JNZ, 3'd2, 3'd3, r2[15:0]));
      wait_idle();
      compare_state(3'd0);
    end

    // Error responses.
    apb_read(12'h100);
    check_err("pslverr unmapped read", rd_err, 1'b1);
    apb_write(12'h008, 32'h1234_5678);
    check_err("pslverr unmapped write", rd_err, 1'b1);
    apb_write(ADDR_EFLAGS, 32'hFFFF_FFFF);
    check_err("pslverr EFLAGS write", rd_err, 1'b1);
    apb_read(ADDR_INSTR);
    check_err("pslverr INSTR read", rd_err, 1'b1);
    compare_state(3'd0);

    if (failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/tiny86_pkg.sv
rtl/mem_if.sv
rtl/data_ram.sv
rtl/mem_arbiter.sv
rtl/regfile.sv
rtl/step_exec.sv
rtl/step_apb_regs.sv
rtl/tiny86_top.sv
tb/tiny86_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tiny86 testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tiny86_tb -f sim.f

./obj_dir/Vtiny86_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
grep -q "Verification passed" sim.log
